//--- design/bus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host bus types for the system board glue
// one sampled 8088 bus cycle per clock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package bus_pkg;

   typedef logic [19:0] addr_t;   // 1 MB host address space
   typedef logic [7:0]  data_t;   // 8-bit external data bus

   // one bus cycle as seen on the system side of the bus controller
   // strobes are active high and last a single clock
   typedef struct packed {
      addr_t addr;
      data_t data;
      logic  ior;
      logic  iow;
      logic  memr;
      logic  memw;
      logic  aen;    // dma owns the bus, blocks i/o decode
   } bus_cycle_t;

endpackage

`default_nettype wire

//--- design/board_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// board decode types, port offsets and register bit positions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package board_pkg;

   // one bit per i/o port group, group 0 in the msb
   typedef struct packed {
      logic dma;       // 0x000
      logic pic;       // 0x020
      logic pit;       // 0x040
      logic ppi;       // 0x060
      logic dma_pg;    // 0x080
      logic nmi_reg;   // 0x0a0
   } io_sel_t;

   typedef logic [1:0] bank_t;       // 64 KB ram bank
   typedef logic [2:0] rom_chip_t;   // 8 KB rom chip

   typedef struct packed {
      logic      ram_sel;
      bank_t     ram_bank;
      logic      rom_sel;
      rom_chip_t rom_chip;
      logic      rd;        // memory read cycle
   } mem_sel_t;

   // port B fields used outside the register block
   typedef struct packed {
      logic tim2_gate;
      logic spkr_data;
      logic perr_en_n;
      logic iochk_en_n;
   } ctrl_t;

   localparam logic [1:0] PORT_B_OFS       = 2'd1;   // within group 3
   localparam logic [1:0] PORT_C_OFS       = 2'd2;
   localparam logic [3:0] ROM_SEGMENT      = 4'hf;   // address 19..16
   localparam logic [4:0] RAM_TOP_BANK_BIT = 5'd18;  // 19..18 zero for ram

   // status byte (port C)
   localparam logic [2:0] STATUS_PCK_BIT   = 3'd7;
   localparam logic [2:0] STATUS_IOCHK_BIT = 3'd6;
   localparam logic [2:0] STATUS_TIM2_BIT  = 3'd5;

   localparam logic [2:0] NMI_MASK_BIT     = 3'd7;

   // port B byte
   localparam logic [2:0] PB_TIM2_GATE_BIT = 3'd0;
   localparam logic [2:0] PB_SPKR_DATA_BIT = 3'd1;
   localparam logic [2:0] PB_PERR_EN_BIT   = 3'd4;   // active low
   localparam logic [2:0] PB_IOCHK_EN_BIT  = 3'd5;   // active low

endpackage

`default_nettype wire

//--- design/bus_sampler.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus sampler: registers each host bus cycle and brings the
// asynchronous board inputs into the clock domain
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module bus_sampler #(
   parameter int SYNC_STAGES = 2
) (
   input  logic                clk_i,
   input  logic                reset_n_i,
   input  bus_pkg::bus_cycle_t bus_i,
   input  logic                ram_perr_i,
   input  logic                io_ch_ck_n_i,
   input  logic                tim2_out_i,
   output bus_pkg::bus_cycle_t cyc_o,
   output logic                perr_o,
   output logic                iochk_o,
   output logic                tim2_o
);

   bus_pkg::addr_t addr_q;
   bus_pkg::data_t data_q;
   logic [4:0]     strb_q;   // ior, iow, memr, memw, aen

   // each stage carries {tim2, iochk}
   logic [SYNC_STAGES-1:0][1:0] sync_q;

   always_ff @(posedge clk_i or negedge reset_n_i) begin
      if (!reset_n_i) begin
         strb_q <= '0;
         perr_o <= 1'b0;
      end else begin
         strb_q <= {bus_i.ior, bus_i.iow, bus_i.memr, bus_i.memw, bus_i.aen};
         perr_o <= ram_perr_i;   // travels with its cycle
      end
   end

   always_ff @(posedge clk_i) begin
      addr_q <= bus_i.addr;
      data_q <= bus_i.data;
   end

   assign cyc_o = {addr_q, data_q, strb_q};   // same order as bus_cycle_t

   // channel check inverted on entry so the chain is active high
   always_ff @(posedge clk_i or negedge reset_n_i) begin
      if (!reset_n_i) begin
         sync_q <= '0;
      end else begin
         sync_q <= {sync_q[SYNC_STAGES-2:0], {tim2_out_i, ~io_ch_ck_n_i}};
      end
   end

   assign iochk_o = sync_q[SYNC_STAGES-1][0];
   assign tim2_o  = sync_q[SYNC_STAGES-1][1];

endmodule

`default_nettype wire

//--- design/addr_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address decoder: i/o port groups, ram banks and rom chips
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module addr_decoder (
   input  logic                clk_i,
   input  logic                reset_n_i,
   input  bus_pkg::bus_cycle_t cyc_i,
   input  logic                perr_i,
   output board_pkg::io_sel_t  io_sel_o,
   output board_pkg::mem_sel_t mem_sel_o,
   output bus_pkg::bus_cycle_t cyc_o,
   output logic                perr_rd_o
);

   board_pkg::io_sel_t  io_sel_c;
   board_pkg::mem_sel_t mem_sel_c;
   logic                io_en;
   logic                rom_hit;
   logic                ram_hit;

   // only bits 9..5 take part, so every port aliases within its group
   assign io_en = (cyc_i.addr[9:8] == 2'b00) && !cyc_i.aen && (cyc_i.ior || cyc_i.iow);

   assign rom_hit = cyc_i.memr && (cyc_i.addr[19:16] == board_pkg::ROM_SEGMENT);
   assign ram_hit = (cyc_i.memr || cyc_i.memw)
                    && (cyc_i.addr[19:board_pkg::RAM_TOP_BANK_BIT] == '0);

   always_comb begin
      io_sel_c = '0;
      if (io_en) begin
         case (cyc_i.addr[7:5])
            3'd0:    io_sel_c.dma     = 1'b1;
            3'd1:    io_sel_c.pic     = 1'b1;
            3'd2:    io_sel_c.pit     = 1'b1;
            3'd3:    io_sel_c.ppi     = 1'b1;
            3'd4:    io_sel_c.dma_pg  = 1'b1;
            3'd5:    io_sel_c.nmi_reg = 1'b1;
            default: io_sel_c         = '0;   // 0x0c0 and 0x0e0 are free
         endcase
      end
   end

   always_comb begin
      mem_sel_c.ram_sel  = ram_hit;
      mem_sel_c.ram_bank = cyc_i.addr[17:16];
      mem_sel_c.rom_sel  = rom_hit;
      mem_sel_c.rom_chip = cyc_i.addr[15:13];
      mem_sel_c.rd       = cyc_i.memr;
   end

   always_ff @(posedge clk_i or negedge reset_n_i) begin
      if (!reset_n_i) begin
         io_sel_o  <= '0;
         mem_sel_o <= '0;
         perr_rd_o <= 1'b0;
      end else begin
         io_sel_o  <= io_sel_c;
         mem_sel_o <= mem_sel_c;
         perr_rd_o <= mem_sel_c.ram_sel && mem_sel_c.rd && perr_i;   // parity only on reads
      end
   end

   // cycle follows its decode for the register block
   always_ff @(posedge clk_i) begin
      cyc_o <= cyc_i;
   end

   // ranges must not overlap, and one i/o group per cycle
   assert property (@(posedge clk_i) disable iff (!reset_n_i)
      $onehot0(io_sel_o) && !(mem_sel_o.rom_sel && mem_sel_o.ram_sel))
      else $error("addr_decoder: more than one select active");

endmodule

`default_nettype wire

//--- design/sys_ctrl_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// system control port B, nmi mask and port read mux
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module sys_ctrl_regs (
   input  logic                clk_i,
   input  logic                reset_n_i,
   input  bus_pkg::bus_cycle_t cyc_i,
   input  board_pkg::io_sel_t  io_sel_i,
   input  logic                pck_i,
   input  logic                iochk_i,
   input  logic                tim2_i,
   output board_pkg::ctrl_t    ctrl_o,
   output logic                nmi_mask_o,
   output bus_pkg::data_t      rd_data_o,
   output logic                rd_hit_o
);

   bus_pkg::data_t port_b_q;
   bus_pkg::data_t status;
   logic           ofs_b;
   logic           ofs_c;
   logic           pb_wr;
   logic           mask_wr;

   assign ofs_b = (cyc_i.addr[1:0] == board_pkg::PORT_B_OFS);
   assign ofs_c = (cyc_i.addr[1:0] == board_pkg::PORT_C_OFS);

   assign pb_wr   = io_sel_i.ppi && cyc_i.iow && ofs_b;
   assign mask_wr = io_sel_i.nmi_reg && cyc_i.iow;   // any offset in group 5

   always_ff @(posedge clk_i or negedge reset_n_i) begin
      if (!reset_n_i) begin
         port_b_q   <= '0;     // both checks enabled
         nmi_mask_o <= 1'b0;
      end else begin
         if (pb_wr) begin
            port_b_q <= cyc_i.data;
         end
         if (mask_wr) begin
            nmi_mask_o <= cyc_i.data[board_pkg::NMI_MASK_BIT];
         end
      end
   end

   always_comb begin
      ctrl_o.tim2_gate  = port_b_q[board_pkg::PB_TIM2_GATE_BIT];
      ctrl_o.spkr_data  = port_b_q[board_pkg::PB_SPKR_DATA_BIT];
      ctrl_o.perr_en_n  = port_b_q[board_pkg::PB_PERR_EN_BIT];
      ctrl_o.iochk_en_n = port_b_q[board_pkg::PB_IOCHK_EN_BIT];
   end

   // port C, unused bits read as zero
   always_comb begin
      status                               = '0;
      status[board_pkg::STATUS_PCK_BIT]    = pck_i;
      status[board_pkg::STATUS_IOCHK_BIT]  = iochk_i;
      status[board_pkg::STATUS_TIM2_BIT]   = tim2_i;
      rd_data_o = ofs_b ? port_b_q : status;
   end

   assign rd_hit_o = io_sel_i.ppi && cyc_i.ior && (ofs_b || ofs_c);

   // the bus controller never issues ior and iow in one cycle
   assert property (@(posedge clk_i) disable iff (!reset_n_i)
      rd_hit_o |-> !cyc_i.iow)
      else $error("sys_ctrl_regs: port read overlaps a write strobe");

endmodule

`default_nettype wire

//--- design/nmi_check.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// parity and i/o channel check latches, nmi request
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module nmi_check (
   input  logic             clk_i,
   input  logic             reset_n_i,
   input  logic             perr_rd_i,
   input  logic             iochk_i,
   input  board_pkg::ctrl_t ctrl_i,
   input  logic             nmi_mask_i,
   output logic             pck_o,
   output logic             iochk_o,
   output logic             nmi_o
);

   // enable high holds a latch clear, low lets an error set it
   always_ff @(posedge clk_i or negedge reset_n_i) begin
      if (!reset_n_i) begin
         pck_o   <= 1'b0;
         iochk_o <= 1'b0;
      end else begin
         if (ctrl_i.perr_en_n) begin
            pck_o <= 1'b0;
         end else if (perr_rd_i) begin
            pck_o <= 1'b1;
         end

         if (ctrl_i.iochk_en_n) begin
            iochk_o <= 1'b0;
         end else if (iochk_i) begin
            iochk_o <= 1'b1;   // card pulled io_ch_ck low
         end
      end
   end

   // registered again on the pin side
   assign nmi_o = nmi_mask_i && (pck_o || iochk_o);

endmodule

`default_nettype wire

//--- design/board_outputs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// output pins: active-low selects, read data, speaker, nmi
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module board_outputs (
   input  logic                clk_i,
   input  logic                reset_n_i,
   input  board_pkg::io_sel_t  io_sel_i,
   input  board_pkg::mem_sel_t mem_sel_i,
   input  bus_pkg::data_t      rd_data_i,
   input  logic                rd_hit_i,
   input  board_pkg::ctrl_t    ctrl_i,
   input  logic                tim2_i,
   input  logic                nmi_i,
   output logic [5:0]          io_cs_n_o,   // dma in bit 5 down to nmi_reg in bit 0
   output logic [3:0]          ras_n_o,
   output logic [3:0]          cas_n_o,
   output logic [7:0]          rom_cs_n_o,
   output bus_pkg::data_t      rd_data_o,
   output logic                rd_valid_o,
   output logic                spkr_o,
   output logic                tim2_gate_o,
   output logic                nmi_o
);

   logic [3:0] ram_cold;
   logic [7:0] rom_cold;

   always_comb begin
      ram_cold = '1;
      rom_cold = '1;
      if (mem_sel_i.ram_sel) begin
         ram_cold[mem_sel_i.ram_bank] = 1'b0;
      end
      if (mem_sel_i.rom_sel) begin
         rom_cold[mem_sel_i.rom_chip] = 1'b0;
      end
   end

   always_ff @(posedge clk_i or negedge reset_n_i) begin
      if (!reset_n_i) begin
         io_cs_n_o   <= '1;
         ras_n_o     <= '1;
         cas_n_o     <= '1;
         rom_cs_n_o  <= '1;
         rd_valid_o  <= 1'b0;
         spkr_o      <= 1'b0;
         tim2_gate_o <= 1'b0;
         nmi_o       <= 1'b0;
      end else begin
         io_cs_n_o   <= ~io_sel_i;
         ras_n_o     <= ram_cold;
         cas_n_o     <= ram_cold;   // no ras-to-cas delay
         rom_cs_n_o  <= rom_cold;
         rd_valid_o  <= rd_hit_i;
         spkr_o      <= tim2_i && ctrl_i.spkr_data;
         tim2_gate_o <= ctrl_i.tim2_gate;
         nmi_o       <= nmi_i;
      end
   end

   always_ff @(posedge clk_i) begin
      rd_data_o <= rd_data_i;   // qualified by rd_valid_o
   end

   assert property (@(posedge clk_i) disable iff (!reset_n_i)
      $onehot0(~ras_n_o))
      else $error("board_outputs: more than one ram bank strobed");

endmodule

`default_nettype wire

//--- design/glue_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// system board glue controller, top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module glue_top #(
   parameter int SYNC_STAGES = 2
) (
   input  logic                clk,
   input  logic                reset_n,
   input  bus_pkg::bus_cycle_t bus_i,
   input  logic                ram_perr_i,
   input  logic                io_ch_ck_n_i,   // async
   input  logic                tim2_out_i,     // async
   output logic [5:0]          io_cs_n_o,
   output logic [3:0]          ras_n_o,
   output logic [3:0]          cas_n_o,
   output logic [7:0]          rom_cs_n_o,
   output bus_pkg::data_t      rd_data_o,
   output logic                rd_valid_o,
   output logic                spkr_o,
   output logic                tim2_gate_o,
   output logic                nmi_o
);

   bus_pkg::bus_cycle_t cyc_s;
   bus_pkg::bus_cycle_t cyc_d;
   logic                perr_s;
   logic                iochk_s;
   logic                tim2_s;
   board_pkg::io_sel_t  io_sel_d;
   board_pkg::mem_sel_t mem_sel_d;
   logic                perr_rd_d;
   board_pkg::ctrl_t    ctrl;
   logic                nmi_mask;
   bus_pkg::data_t      rd_data_c;
   logic                rd_hit_c;
   logic                pck;
   logic                iochk;
   logic                nmi_c;

   bus_sampler #(
      .SYNC_STAGES (SYNC_STAGES)
   ) u_bus_sampler (
      .clk_i        (clk),
      .reset_n_i    (reset_n),
      .bus_i        (bus_i),
      .ram_perr_i   (ram_perr_i),
      .io_ch_ck_n_i (io_ch_ck_n_i),
      .tim2_out_i   (tim2_out_i),
      .cyc_o        (cyc_s),
      .perr_o       (perr_s),
      .iochk_o      (iochk_s),
      .tim2_o       (tim2_s)
   );

   addr_decoder u_addr_decoder (
      .clk_i     (clk),
      .reset_n_i (reset_n),
      .cyc_i     (cyc_s),
      .perr_i    (perr_s),
      .io_sel_o  (io_sel_d),
      .mem_sel_o (mem_sel_d),
      .cyc_o     (cyc_d),
      .perr_rd_o (perr_rd_d)
   );

   sys_ctrl_regs u_sys_ctrl_regs (
      .clk_i      (clk),
      .reset_n_i  (reset_n),
      .cyc_i      (cyc_d),
      .io_sel_i   (io_sel_d),
      .pck_i      (pck),
      .iochk_i    (iochk),
      .tim2_i     (tim2_s),
      .ctrl_o     (ctrl),
      .nmi_mask_o (nmi_mask),
      .rd_data_o  (rd_data_c),
      .rd_hit_o   (rd_hit_c)
   );

   nmi_check u_nmi_check (
      .clk_i      (clk),
      .reset_n_i  (reset_n),
      .perr_rd_i  (perr_rd_d),
      .iochk_i    (iochk_s),
      .ctrl_i     (ctrl),
      .nmi_mask_i (nmi_mask),
      .pck_o      (pck),
      .iochk_o    (iochk),
      .nmi_o      (nmi_c)
   );

   board_outputs u_board_outputs (
      .clk_i       (clk),
      .reset_n_i   (reset_n),
      .io_sel_i    (io_sel_d),
      .mem_sel_i   (mem_sel_d),
      .rd_data_i   (rd_data_c),
      .rd_hit_i    (rd_hit_c),
      .ctrl_i      (ctrl),
      .tim2_i      (tim2_s),
      .nmi_i       (nmi_c),
      .io_cs_n_o   (io_cs_n_o),
      .ras_n_o     (ras_n_o),
      .cas_n_o     (cas_n_o),
      .rom_cs_n_o  (rom_cs_n_o),
      .rd_data_o   (rd_data_o),
      .rd_valid_o  (rd_valid_o),
      .spkr_o      (spkr_o),
      .tim2_gate_o (tim2_gate_o),
      .nmi_o       (nmi_o)
   );

endmodule

`default_nettype wire

//--- sim/glue_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the system board glue controller
// random and directed bus cycles against a reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module glue_tb;

   localparam int CLK_PERIOD      = 8;
   localparam int RESET_CYCLES    = 10;
   localparam int N_IO_CYCLES     = 400;
   localparam int N_MEM_CYCLES    = 400;
   localparam int DIRECTED_CYCLES = 300;   // upper bound for the port and nmi tests
   localparam int POLL_LIMIT      = 16;
   localparam int PIN_NMI         = 0;
   localparam int PIN_SPKR        = 1;

   // strobes in the order ior, iow, memr, memw
   localparam logic [3:0] S_IDLE = 4'b0000;
   localparam logic [3:0] S_IOR  = 4'b1000;
   localparam logic [3:0] S_IOW  = 4'b0100;
   localparam logic [3:0] S_MEMR = 4'b0010;
   localparam logic [3:0] S_MEMW = 4'b0001;

   typedef struct packed {
      logic [5:0]     io_cs_n;
      logic [3:0]     ras_n;
      logic [3:0]     cas_n;
      logic [7:0]     rom_cs_n;
      logic           rd_valid;
      bus_pkg::data_t rd_data;
      logic           data_known;   // clear for status polls
      int             due;          // edge count once the pins hold the result
   } expect_t;

   logic                clk = 1'b0;
   logic                reset_n;
   bus_pkg::bus_cycle_t bus_i;
   logic                ram_perr_i;
   logic                io_ch_ck_n_i;
   logic                tim2_out_i;
   logic [5:0]          io_cs_n_o;
   logic [3:0]          ras_n_o;
   logic [3:0]          cas_n_o;
   logic [7:0]          rom_cs_n_o;
   bus_pkg::data_t      rd_data_o;
   logic                rd_valid_o;
   logic                spkr_o;
   logic                tim2_gate_o;
   logic                nmi_o;

   int          edge_cnt = 0;
   logic [15:0] lfsr_q   = 16'd69;
   expect_t     exp_q[$];

   // model of port B, the mask and the check latches
   bus_pkg::data_t m_port_b;
   logic           m_mask;
   logic           m_pck;
   logic           m_iochk;
   logic           m_tim2;

   glue_top #(
      .SYNC_STAGES (2)
   ) u_dut (
      .clk          (clk),
      .reset_n      (reset_n),
      .bus_i        (bus_i),
      .ram_perr_i   (ram_perr_i),
      .io_ch_ck_n_i (io_ch_ck_n_i),
      .tim2_out_i   (tim2_out_i),
      .io_cs_n_o    (io_cs_n_o),
      .ras_n_o      (ras_n_o),
      .cas_n_o      (cas_n_o),
      .rom_cs_n_o   (rom_cs_n_o),
      .rd_data_o    (rd_data_o),
      .rd_valid_o   (rd_valid_o),
      .spkr_o       (spkr_o),
      .tim2_gate_o  (tim2_gate_o),
      .nmi_o        (nmi_o)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   always @(posedge clk) edge_cnt <= edge_cnt + 1;

   task automatic fail_run();
      $display("TEST RESULT: FAIL");
      $fatal(1);
   endtask

   task automatic stop_on_error(input string msg);
      $display("ERROR: %s", msg);
      fail_run();
   endtask

   task automatic check_io_cs(input string name, input logic [5:0] got, input logic [5:0] want);
      if (got !== want) begin
         $display("MISMATCH %s: got %h expected %h", name, got, want);
         fail_run();
      end
   endtask

   task automatic check_bank(input string name, input logic [3:0] got, input logic [3:0] want);
      if (got !== want) begin
         $display("MISMATCH %s: got %h expected %h", name, got, want);
         fail_run();
      end
   endtask

   task automatic check_rom(input string name, input logic [7:0] got, input logic [7:0] want);
      if (got !== want) begin
         $display("MISMATCH %s: got %h expected %h", name, got, want);
         fail_run();
      end
   endtask

   task automatic check_data(input string name, input bus_pkg::data_t got,
                             input bus_pkg::data_t want);
      if (got !== want) begin
         $display("MISMATCH %s: got %h expected %h", name, got, want);
         fail_run();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic want);
      if (got !== want) begin
         $display("MISMATCH %s: got %h expected %h", name, got, want);
         fail_run();
      end
   endtask

   // x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
         lfsr_q = {lfsr_q[14:0], fb};
         r      = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic bus_pkg::bus_cycle_t make_cycle(input bus_pkg::addr_t addr,
         input bus_pkg::data_t data, input logic [3:0] strb, input logic aen);
      bus_pkg::bus_cycle_t c;
      c.addr = addr;
      c.data = data;
      c.ior  = strb[3];
      c.iow  = strb[2];
      c.memr = strb[1];
      c.memw = strb[0];
      c.aen  = aen;
      return c;
   endfunction

   // port address in a group, with random alias bits 4..2
   function automatic bus_pkg::addr_t io_addr(input logic [2:0] grp, input logic [1:0] ofs);
      logic [31:0] r;
      r = take_bits(3);
      return {10'h000, 2'b00, grp, r[2:0], ofs};
   endfunction

   // expected pins for one cycle, from the decode rules and the register model
   function automatic expect_t predict(input bus_pkg::bus_cycle_t c);
      expect_t    e;
      logic [2:0] grp;
      logic [2:0] pos;
      logic       io_hit;
      grp          = c.addr[7:5];
      pos          = 3'd5 - grp;   // group 0 sits in the msb
      io_hit       = (c.addr[9:8] == 2'b00) && !c.aen && (c.ior || c.iow) && (grp <= 3'd5);
      e.io_cs_n    = 6'h3f;
      e.ras_n      = 4'hf;
      e.rom_cs_n   = 8'hff;
      e.rd_valid   = 1'b0;
      e.rd_data    = 8'h00;
      e.data_known = 1'b1;
      e.due        = 0;
      if (io_hit) begin
         e.io_cs_n[pos] = 1'b0;
      end
      if (c.memr && c.addr[19:16] == 4'hf) begin
         e.rom_cs_n[c.addr[15:13]] = 1'b0;
      end
      if ((c.memr || c.memw) && c.addr[19:18] == 2'b00) begin
         e.ras_n[c.addr[17:16]] = 1'b0;
      end
      e.cas_n = e.ras_n;
      if (io_hit && grp == 3'd3 && c.ior && (c.addr[1:0] == 2'd1 || c.addr[1:0] == 2'd2)) begin
         e.rd_valid = 1'b1;
         e.rd_data  = (c.addr[1:0] == 2'd1) ? m_port_b : {m_pck, m_iochk, m_tim2, 5'b00000};
      end
      return e;
   endfunction

   function automatic void update_model(input bus_pkg::bus_cycle_t c, input logic perr);
      logic io_wr;
      io_wr = (c.addr[9:8] == 2'b00) && !c.aen && c.iow;
      if (io_wr && c.addr[7:5] == 3'd3 && c.addr[1:0] == 2'd1) begin
         m_port_b = c.data;
         if (c.data[4]) begin
            m_pck = 1'b0;
         end
         if (c.data[5]) begin
            m_iochk = 1'b0;
         end
      end
      if (io_wr && c.addr[7:5] == 3'd5) begin
         m_mask = c.data[7];
      end
      if (perr && c.memr && c.addr[19:18] == 2'b00 && !m_port_b[4]) begin
         m_pck = 1'b1;
      end
   endfunction

   task automatic drive_cycle(input bus_pkg::bus_cycle_t c, input logic perr, input logic known);
      expect_t e;
      @(posedge clk);
      #1;
      bus_i        = c;
      ram_perr_i   = perr;
      e            = predict(c);
      e.data_known = known;
      e.due        = edge_cnt + 3;   // sampled at the next edge, pins after two more
      exp_q.push_back(e);
      update_model(c, perr);
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) drive_cycle(make_cycle(20'h00000, 8'h00, S_IDLE, 1'b0), 1'b0, 1'b1);
   endtask

   task automatic write_io(input bus_pkg::addr_t addr, input bus_pkg::data_t data);
      drive_cycle(make_cycle(addr, data, S_IOW, 1'b0), 1'b0, 1'b1);
      idle_cycles(2);   // latches follow one edge after the register
   endtask

   task automatic read_io(input bus_pkg::addr_t addr);
      drive_cycle(make_cycle(addr, 8'h00, S_IOR, 1'b0), 1'b0, 1'b1);
   endtask

   // repeated status reads until the given bit shows up
   task automatic wait_for_status(input logic [2:0] bit_pos);
      bus_pkg::data_t got;
      int             tries;
      got   = '0;
      tries = 0;
      while (!got[bit_pos]) begin
         if (tries == POLL_LIMIT) begin
            stop_on_error("status bit was never set by the check input");
         end
         drive_cycle(make_cycle(io_addr(3'd3, 2'd2), 8'h00, S_IOR, 1'b0), 1'b0, 1'b0);
         idle_cycles(3);   // read data on the pins after the third edge
         got   = rd_data_o;
         tries = tries + 1;
      end
   endtask

   function automatic logic pin_value(input int sel);
      return (sel == PIN_NMI) ? nmi_o : spkr_o;
   endfunction

   task automatic wait_for_pin(input int sel, input logic want, input string name);
      int tries;
      tries = 0;
      while (pin_value(sel) !== want) begin
         if (tries == POLL_LIMIT) begin
            stop_on_error({name, " did not reach the expected level in time"});
         end
         idle_cycles(1);
         tries = tries + 1;
      end
   endtask

   task automatic check_reset_pins();
      check_io_cs("io_cs_n_o", io_cs_n_o, 6'h3f);
      check_bank("ras_n_o", ras_n_o, 4'hf);
      check_bank("cas_n_o", cas_n_o, 4'hf);
      check_rom("rom_cs_n_o", rom_cs_n_o, 8'hff);
      check_bit("rd_valid_o", rd_valid_o, 1'b0);
      check_bit("spkr_o", spkr_o, 1'b0);
      check_bit("tim2_gate_o", tim2_gate_o, 1'b0);
      check_bit("nmi_o", nmi_o, 1'b0);
   endtask

   // every driven cycle is compared on the cycle after its E2
   always @(negedge clk) begin : compare_outputs
      expect_t e;
      if (exp_q.size() > 0 && exp_q[0].due < edge_cnt) begin
         stop_on_error("an expected response was skipped by the checker");
      end
      if (exp_q.size() > 0 && exp_q[0].due == edge_cnt) begin
         e = exp_q.pop_front();
         check_io_cs("io_cs_n_o", io_cs_n_o, e.io_cs_n);
         check_bank("ras_n_o", ras_n_o, e.ras_n);
         check_bank("cas_n_o", cas_n_o, e.cas_n);
         check_rom("rom_cs_n_o", rom_cs_n_o, e.rom_cs_n);
         check_bit("rd_valid_o", rd_valid_o, e.rd_valid);
         if (e.rd_valid && e.data_known) begin
            check_data("rd_data_o", rd_data_o, e.rd_data);
         end
      end
   end

   initial begin : watchdog
      #(2 * (RESET_CYCLES + N_IO_CYCLES + N_MEM_CYCLES + DIRECTED_CYCLES) * CLK_PERIOD);
      stop_on_error("watchdog expired before the test sequence finished");
   end

   initial begin : run_tests
      logic [31:0]    r;
      bus_pkg::addr_t a;
      bus_pkg::data_t pb;
      logic [3:0]     strb;
      logic           aen;
      reset_n      = 1'b0;
      bus_i        = make_cycle(20'h00000, 8'h00, S_IDLE, 1'b0);
      ram_perr_i   = 1'b0;
      io_ch_ck_n_i = 1'b1;
      tim2_out_i   = 1'b0;
      m_port_b     = 8'h00;
      m_mask       = 1'b0;
      m_pck        = 1'b0;
      m_iochk      = 1'b0;
      m_tim2       = 1'b0;

      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      check_reset_pins();
      reset_n = 1'b1;

      // random i/o cycles, aliases and aen included
      for (int i = 0; i < N_IO_CYCLES; i++) begin
         r = take_bits(10);
         a = {10'h000, r[9:0]};
         r = take_bits(1);
         if (r[0]) begin
            a[9:8] = 2'b00;   // mostly inside the board range
         end
         r = take_bits(2);
         case (r[1:0])
            2'd0:    strb = S_IDLE;
            2'd2:    strb = S_IOW;
            default: strb = S_IOR;
         endcase
         r   = take_bits(2);
         aen = r[1] & r[0];
         r   = take_bits(8);
         drive_cycle(make_cycle(a, r[7:0], strb, aen), 1'b0, 1'b1);
      end

      // random memory cycles, biased toward ram and rom
      for (int i = 0; i < N_MEM_CYCLES; i++) begin
         r = take_bits(20);
         a = r[19:0];
         r = take_bits(2);
         if (r[1:0] == 2'd0) begin
            a[19:18] = 2'b00;
         end else if (r[1:0] == 2'd1) begin
            a[19:16] = 4'hf;
         end
         r    = take_bits(1);
         strb = r[0] ? S_MEMW : S_MEMR;
         drive_cycle(make_cycle(a, 8'h00, strb, 1'b0), 1'b0, 1'b1);
      end
      idle_cycles(2);

      // port B write and alias read back, then speaker follows the timer
      r  = take_bits(8);
      pb = r[7:0] | 8'h02;
      write_io(io_addr(3'd3, 2'd1), pb);
      read_io(io_addr(3'd3, 2'd1));
      idle_cycles(3);
      check_bit("tim2_gate_o", tim2_gate_o, pb[0]);
      check_bit("spkr_o", spkr_o, 1'b0);
      tim2_out_i = 1'b1;
      wait_for_pin(PIN_SPKR, 1'b1, "spkr_o");
      m_tim2 = 1'b1;
      read_io(io_addr(3'd3, 2'd2));
      idle_cycles(2);   // timer held until the status read is captured
      tim2_out_i = 1'b0;
      wait_for_pin(PIN_SPKR, 1'b0, "spkr_o");
      m_tim2 = 1'b0;
      check_bit("tim2_gate_o", tim2_gate_o, pb[0]);

      // channel check with the nmi mask
      write_io(io_addr(3'd5, 2'd0), 8'h00);
      write_io(io_addr(3'd3, 2'd1), 8'h10);   // parity off, channel check on
      io_ch_ck_n_i = 1'b0;
      wait_for_status(3'd6);
      m_iochk = 1'b1;
      idle_cycles(4);
      check_bit("nmi_o", nmi_o, 1'b0);   // still masked
      read_io(io_addr(3'd3, 2'd2));
      r = take_bits(7);
      write_io(io_addr(3'd5, 2'd3), {1'b1, r[6:0]});
      wait_for_pin(PIN_NMI, 1'b1, "nmi_o");
      write_io(io_addr(3'd3, 2'd1), 8'h30);
      wait_for_pin(PIN_NMI, 1'b0, "nmi_o");
      read_io(io_addr(3'd3, 2'd2));
      io_ch_ck_n_i = 1'b1;
      idle_cycles(6);
      write_io(io_addr(3'd3, 2'd1), 8'h10);
      read_io(io_addr(3'd3, 2'd2));
      idle_cycles(3);
      check_bit("nmi_o", nmi_o, 1'b0);

      // parity check on ram reads
      write_io(io_addr(3'd3, 2'd1), 8'h00);
      r = take_bits(18);
      a = {2'b00, r[17:0]};
      drive_cycle(make_cycle(a, 8'h00, S_MEMR, 1'b0), 1'b1, 1'b1);
      idle_cycles(1);
      read_io(io_addr(3'd3, 2'd2));
      wait_for_pin(PIN_NMI, 1'b1, "nmi_o");
      write_io(io_addr(3'd3, 2'd1), 8'h10);   // disable clears the latch
      read_io(io_addr(3'd3, 2'd2));
      wait_for_pin(PIN_NMI, 1'b0, "nmi_o");
      drive_cycle(make_cycle(a, 8'h00, S_MEMR, 1'b0), 1'b1, 1'b1);
      idle_cycles(1);
      read_io(io_addr(3'd3, 2'd2));
      write_io(io_addr(3'd3, 2'd1), 8'h00);
      drive_cycle(make_cycle(a, 8'h5a, S_MEMW, 1'b0), 1'b1, 1'b1);   // writes never set it
      idle_cycles(1);
      read_io(io_addr(3'd3, 2'd2));
      idle_cycles(4);
      check_bit("nmi_o", nmi_o, 1'b0);
      idle_cycles(2);

      repeat (6) @(negedge clk);
      if (exp_q.size() != 0) begin
         stop_on_error("responses were still outstanding at the end of the run");
      end else begin
         $display("TEST RESULT: PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- src.f
design/bus_pkg.sv
design/board_pkg.sv
design/bus_sampler.sv
design/addr_decoder.sv
design/sys_ctrl_regs.sv
design/nmi_check.sv
design/board_outputs.sv
design/glue_top.sv
sim/glue_tb.sv

//--- Makefile
# Verilator build and run for the system board glue controller

TOP = glue_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -o V$(TOP)

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert --top-module glue_top -f src.f

clean:
	rm -rf obj_dir
